/* project.f */
common/masked_alu_pkg.sv
execute/masked_shift.sv
execute/masked_execute.sv
design/masked_decode.sv
design/masked_result.sv
design/masked_alu_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
  --top-module tb_top -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/tb_top.sv */
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  g_clk;
  logic                  g_resetn;
  logic                  valid;
  logic                  flush;
  logic                  prng_update;
  masked_alu_pkg::op_t   op;
  masked_alu_pkg::word_t rs1_s0, rs1_s1, rs2_s0, rs2_s1;
  logic                  ready;
  masked_alu_pkg::word_t rd_s0, rd_s1;
  int                    pending, checks, errors;
  int                    timeouts = 0;
  int unsigned           seed_val;
  masked_alu_pkg::word_t m0, m1, m2, m3;

  tb_clock u_clk (.o_clk(g_clk), .o_resetn(g_resetn));

  masked_alu_top u_dut (
    .g_clk    (g_clk),    .g_resetn (g_resetn),
    .i_valid  (valid),    .i_flush  (flush),
    .i_prng_update (prng_update),
    .i_op     (op),
    .i_rs1_s0 (rs1_s0),   .i_rs1_s1 (rs1_s1),
    .i_rs2_s0 (rs2_s0),   .i_rs2_s1 (rs2_s1),
    .o_ready  (ready),
    .o_rd_s0  (rd_s0),    .o_rd_s1  (rd_s1)
  );

  tb_checker u_chk (
    .g_clk    (g_clk),    .g_resetn (g_resetn),
    .i_valid  (valid),    .i_flush  (flush),    .i_op     (op),
    .i_rs1_s0 (rs1_s0),   .i_rs1_s1 (rs1_s1),
    .i_rs2_s0 (rs2_s0),   .i_rs2_s1 (rs2_s1),
    .i_ready  (ready),    .i_rd_s0  (rd_s0),    .i_rd_s1  (rd_s1),
    .o_pending (pending), .o_checks (checks),   .o_errors (errors)
  );

  task automatic issue(input masked_alu_pkg::op_t op_in,
                       input masked_alu_pkg::word_t a0, a1, b0, b1);
    @(posedge g_clk);
    valid       <= 1'b1;
    flush       <= 1'b0;
    prng_update <= 1'b0;
    op          <= op_in;
    {rs1_s0, rs1_s1, rs2_s0, rs2_s1} <= {a0, a1, b0, b1};
  endtask

  // Random shares with the shift amount in the low bits of rs2 share 0
  task automatic issue_random(input masked_alu_pkg::op_t op_in, input masked_alu_pkg::shamt_t sh);
    masked_alu_pkg::word_t b0;
    b0 = $urandom();
    b0[masked_alu_pkg::SHAMT_W-1:0] = sh;
    issue(op_in, $urandom(), $urandom(), b0, $urandom());
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge g_clk);
      valid       <= 1'b0;
      flush       <= 1'b0;
      prng_update <= 1'b0;
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (g_resetn !== 1'b1 && n < 40) begin
      @(posedge g_clk);
      n++;
    end
    if (g_resetn !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending != 0 && n < 20) begin
      @(negedge g_clk);
      n++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("Timeout: %0d results never came back", pending);
    end
  endtask

  initial begin
    valid       = 1'b1; // An issue held high through reset
    flush       = 1'b0;
    prng_update = 1'b0;
    op          = masked_alu_pkg::OP_B_XOR;
    {rs1_s0, rs1_s1, rs2_s0, rs2_s1} = '0;
    seed_val    = $urandom(32'h572ba461);
    wait_reset();
    valid <= 1'b0;

    // LFSR strobes alone must not complete anything
    repeat (5) begin
      @(posedge g_clk);
      prng_update <= 1'b1;
    end
    idle(4);

    repeat (4) begin
      m0 = $urandom();
      m1 = $urandom();
      m2 = $urandom();
      m3 = $urandom();
      issue(masked_alu_pkg::OP_B_MASK, m0, m1, m2, m3);
      issue(masked_alu_pkg::OP_B_MASK, m0, m1, m2, m3);
      issue(masked_alu_pkg::OP_B_REMASK, m0, m1, m2, m3);
      issue(masked_alu_pkg::OP_B_REMASK, m0, m1, m2, m3);
    end
    idle(1);
    wait_drain();

    // Back-to-back burst of logic operations
    repeat (200) begin
      case ($urandom_range(3))
        0:       issue_random(masked_alu_pkg::OP_B_NOT, '0);
        1:       issue_random(masked_alu_pkg::OP_B_XOR, '0);
        2:       issue_random(masked_alu_pkg::OP_B_AND, '0);
        default: issue_random(masked_alu_pkg::OP_B_IOR, '0);
      endcase
    end
    idle(1);
    wait_drain();

    for (int sh = 0; sh < masked_alu_pkg::XLEN; sh++) begin
      issue_random(masked_alu_pkg::OP_B_SRLI, masked_alu_pkg::shamt_t'(sh));
      issue_random(masked_alu_pkg::OP_B_SLLI, masked_alu_pkg::shamt_t'(sh));
      issue_random(masked_alu_pkg::OP_B_RORI, masked_alu_pkg::shamt_t'(sh));
    end
    idle(1);
    wait_drain();

    // Flush one cycle after an issue, then with an issue on the flush edge
    issue_random(masked_alu_pkg::OP_B_XOR, '0);
    @(posedge g_clk);
    valid <= 1'b0;
    flush <= 1'b1;
    idle(2);
    issue_random(masked_alu_pkg::OP_B_AND, '0);
    @(posedge g_clk);
    flush <= 1'b1; // valid stays high with the same AND
    idle(2);
    issue_random(masked_alu_pkg::OP_B_IOR, '0);
    idle(2);
    wait_drain();
    idle(4);

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_checker.sv */
`default_nettype none

module tb_checker (
  input  logic                  g_clk,
  input  logic                  g_resetn,
  input  logic                  i_valid,
  input  logic                  i_flush,
  input  masked_alu_pkg::op_t   i_op,
  input  masked_alu_pkg::word_t i_rs1_s0,
  input  masked_alu_pkg::word_t i_rs1_s1,
  input  masked_alu_pkg::word_t i_rs2_s0,
  input  masked_alu_pkg::word_t i_rs2_s1,
  input  logic                  i_ready,
  input  masked_alu_pkg::word_t i_rd_s0,
  input  masked_alu_pkg::word_t i_rd_s1,
  output int                    o_pending,
  output int                    o_checks,
  output int                    o_errors
);
  timeunit 1ns;
  timeprecision 100ps;

  masked_alu_pkg::word_t exp_q [$];
  masked_alu_pkg::op_t   op_q [$];
  int                    cyc_q [$];
  int                    cyc = 0;
  int                    pending = 0;
  int                    checks = 0;
  int                    errors = 0;
  logic                  have_msk = 1'b0;
  masked_alu_pkg::word_t last_msk_s1 = '0;

  assign o_pending = pending;
  assign o_checks  = checks;
  assign o_errors  = errors;

  // Unmasked value the DUT should return
  function automatic masked_alu_pkg::word_t ref_result(input masked_alu_pkg::op_t op,
                                                       input masked_alu_pkg::word_t rs1_s0,
                                                       input masked_alu_pkg::word_t rs1,
                                                       input masked_alu_pkg::word_t rs2,
                                                       input masked_alu_pkg::shamt_t sh);
    case (op)
      masked_alu_pkg::OP_B_MASK:   return rs1_s0; // Share 0 is taken as the plain value
      masked_alu_pkg::OP_B_REMASK: return rs1;
      masked_alu_pkg::OP_B_NOT:    return ~rs1;
      masked_alu_pkg::OP_B_XOR:    return rs1 ^ rs2;
      masked_alu_pkg::OP_B_AND:    return rs1 & rs2;
      masked_alu_pkg::OP_B_IOR:    return rs1 | rs2;
      masked_alu_pkg::OP_B_SRLI:   return rs1 >> sh;
      masked_alu_pkg::OP_B_SLLI:   return rs1 << sh;
      masked_alu_pkg::OP_B_RORI:
        return (sh == '0) ? rs1 : (rs1 >> sh) | (rs1 << (masked_alu_pkg::XLEN - int'(sh)));
      default:                     return '0;
    endcase
  endfunction

  always @(posedge g_clk) begin : compare
    masked_alu_pkg::word_t got;
    masked_alu_pkg::word_t want;
    masked_alu_pkg::op_t   op;
    int                    c;
    cyc++;
    if (!g_resetn) begin
      if (i_ready === 1'b1) begin
        errors++;
        $display("error at %0t: o_ready high during reset", $time);
      end
      exp_q.delete();
      op_q.delete();
      cyc_q.delete();
    end else begin
      if (i_ready === 1'b1 && exp_q.size() == 0) begin
        errors++;
        $display("error at %0t: o_ready with no operation in flight", $time);
      end else if (i_ready === 1'b1) begin
        want = exp_q.pop_front();
        op   = op_q.pop_front();
        c    = cyc_q.pop_front();
        got  = i_rd_s0 ^ i_rd_s1;
        checks++;
        if (got !== want) begin
          errors++;
          $display("error at %0t: %s unmasked %h, expected %h", $time, op.name(), got, want);
        end
        if (cyc - c != 2) begin
          errors++;
          $display("error at %0t: %s took %0d cycles, expected 2", $time, op.name(), cyc - c);
        end
        // Share 1 of a mask result is the LFSR word, so it must change
        if (op == masked_alu_pkg::OP_B_MASK || op == masked_alu_pkg::OP_B_REMASK) begin
          if (have_msk && i_rd_s1 === last_msk_s1) begin
            errors++;
            $display("error at %0t: %s share 1 %h not refreshed", $time, op.name(), i_rd_s1);
          end
          have_msk    = 1'b1;
          last_msk_s1 = i_rd_s1;
        end
      end
      if (i_flush === 1'b1) begin
        exp_q.delete(); // In-flight work and a same-edge issue are dropped
        op_q.delete();
        cyc_q.delete();
      end else if (i_valid === 1'b1 && i_op <= masked_alu_pkg::OP_B_RORI) begin
        exp_q.push_back(ref_result(i_op, i_rs1_s0, i_rs1_s0 ^ i_rs1_s1, i_rs2_s0 ^ i_rs2_s1,
                                   i_rs2_s0[masked_alu_pkg::SHAMT_W-1:0]));
        op_q.push_back(i_op);
        cyc_q.push_back(cyc);
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none

module tb_clock (
  output logic o_clk,
  output logic o_resetn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk; // 8 ns period
  end

  // Low for the first 10 rising edges
  initial begin
    o_resetn = 1'b0;
    repeat (10) @(posedge o_clk);
    o_resetn <= 1'b1;
  end

endmodule

`default_nettype wire

/* design/masked_alu_top.sv */
`default_nettype none

module masked_alu_top #(
  parameter masked_alu_pkg::word_t prng_seed = masked_alu_pkg::PRNG_SEED
) (
  input  logic                  g_clk,
  input  logic                  g_resetn,
  input  logic                  i_valid,
  input  logic                  i_flush,
  input  logic                  i_prng_update,
  input  masked_alu_pkg::op_t   i_op,
  input  masked_alu_pkg::word_t i_rs1_s0,
  input  masked_alu_pkg::word_t i_rs1_s1,
  input  masked_alu_pkg::word_t i_rs2_s0,
  input  masked_alu_pkg::word_t i_rs2_s1,
  output logic                  o_ready,
  output masked_alu_pkg::word_t o_rd_s0,
  output masked_alu_pkg::word_t o_rd_s1
);

  // Stage 1, decode to execute
  logic                   d_valid;
  logic                   d_not, d_xor, d_and, d_ior, d_srli, d_slli, d_rori, d_mask, d_remask;
  masked_alu_pkg::word_t  d_a0, d_a1, d_b0, d_b1, d_rand;
  masked_alu_pkg::shamt_t d_shamt;

  // Execute to result, unregistered
  logic                   x_valid;
  logic                   x_not, x_xor, x_and, x_ior, x_srli, x_slli, x_rori, x_mask, x_remask;
  masked_alu_pkg::word_t  x_t0, x_t1, x_t2, x_t3, x_lin0, x_lin1;
  masked_alu_pkg::word_t  x_shf0, x_shf1, x_msk0, x_msk1, x_rand;

  masked_decode #(
    .prng_seed (prng_seed)
  ) u_decode (
    .g_clk       (g_clk),       .g_resetn     (g_resetn),
    .i_valid     (i_valid),     .i_flush      (i_flush),
    .i_prng_update (i_prng_update),
    .i_op        (i_op),
    .i_rs1_s0    (i_rs1_s0),    .i_rs1_s1     (i_rs1_s1),
    .i_rs2_s0    (i_rs2_s0),    .i_rs2_s1     (i_rs2_s1),
    .o_valid     (d_valid),
    .o_is_not    (d_not),       .o_is_xor     (d_xor),
    .o_is_and    (d_and),       .o_is_ior     (d_ior),
    .o_is_srli   (d_srli),      .o_is_slli    (d_slli),
    .o_is_rori   (d_rori),      .o_is_mask    (d_mask),
    .o_is_remask (d_remask),
    .o_a0        (d_a0),        .o_a1         (d_a1),
    .o_b0        (d_b0),        .o_b1         (d_b1),
    .o_shamt     (d_shamt),     .o_rand       (d_rand)
  );

  masked_execute u_execute (
    .i_valid     (d_valid),
    .i_is_not    (d_not),       .i_is_xor     (d_xor),
    .i_is_and    (d_and),       .i_is_ior     (d_ior),
    .i_is_srli   (d_srli),      .i_is_slli    (d_slli),
    .i_is_rori   (d_rori),      .i_is_mask    (d_mask),
    .i_is_remask (d_remask),
    .i_a0        (d_a0),        .i_a1         (d_a1),
    .i_b0        (d_b0),        .i_b1         (d_b1),
    .i_shamt     (d_shamt),     .i_rand       (d_rand),
    .o_valid     (x_valid),
    .o_is_not    (x_not),       .o_is_xor     (x_xor),
    .o_is_and    (x_and),       .o_is_ior     (x_ior),
    .o_is_srli   (x_srli),      .o_is_slli    (x_slli),
    .o_is_rori   (x_rori),      .o_is_mask    (x_mask),
    .o_is_remask (x_remask),
    .o_and_t0    (x_t0),        .o_and_t1     (x_t1),
    .o_and_t2    (x_t2),        .o_and_t3     (x_t3),
    .o_lin0      (x_lin0),      .o_lin1       (x_lin1),
    .o_shf0      (x_shf0),      .o_shf1       (x_shf1),
    .o_msk0      (x_msk0),      .o_msk1       (x_msk1),
    .o_rand      (x_rand)
  );

  masked_result u_result (
    .g_clk       (g_clk),       .g_resetn     (g_resetn),
    .i_flush     (i_flush),     .i_valid      (x_valid),
    .i_is_not    (x_not),       .i_is_xor     (x_xor),
    .i_is_and    (x_and),       .i_is_ior     (x_ior),
    .i_is_srli   (x_srli),      .i_is_slli    (x_slli),
    .i_is_rori   (x_rori),      .i_is_mask    (x_mask),
    .i_is_remask (x_remask),
    .i_and_t0    (x_t0),        .i_and_t1     (x_t1),
    .i_and_t2    (x_t2),        .i_and_t3     (x_t3),
    .i_lin0      (x_lin0),      .i_lin1       (x_lin1),
    .i_shf0      (x_shf0),      .i_shf1       (x_shf1),
    .i_msk0      (x_msk0),      .i_msk1       (x_msk1),
    .i_rand      (x_rand),
    .o_ready     (o_ready),
    .o_rd_s0     (o_rd_s0),     .o_rd_s1      (o_rd_s1)
  );

endmodule

`default_nettype wire

/* design/masked_result.sv */
`default_nettype none

module masked_result (
  input  logic                  g_clk,
  input  logic                  g_resetn,
  input  logic                  i_flush,
  input  logic                  i_valid,
  input  logic                  i_is_not,
  input  logic                  i_is_xor,
  input  logic                  i_is_and,
  input  logic                  i_is_ior,
  input  logic                  i_is_srli,
  input  logic                  i_is_slli,
  input  logic                  i_is_rori,
  input  logic                  i_is_mask,
  input  logic                  i_is_remask,
  input  masked_alu_pkg::word_t i_and_t0,
  input  masked_alu_pkg::word_t i_and_t1,
  input  masked_alu_pkg::word_t i_and_t2,
  input  masked_alu_pkg::word_t i_and_t3,
  input  masked_alu_pkg::word_t i_lin0,
  input  masked_alu_pkg::word_t i_lin1,
  input  masked_alu_pkg::word_t i_shf0,
  input  masked_alu_pkg::word_t i_shf1,
  input  masked_alu_pkg::word_t i_msk0,
  input  masked_alu_pkg::word_t i_msk1,
  input  masked_alu_pkg::word_t i_rand,
  output logic                  o_ready,
  output masked_alu_pkg::word_t o_rd_s0,
  output masked_alu_pkg::word_t o_rd_s1
);

  localparam int XLEN = masked_alu_pkg::XLEN;

  logic                  r_not, r_xor, r_and, r_ior, r_srli, r_slli, r_rori, r_mask, r_remask;
  logic                  sel_lin, sel_shf, sel_msk;
  masked_alu_pkg::word_t t0_q, t1_q, t2_q, t3_q;
  masked_alu_pkg::word_t lin0_q, lin1_q, shf0_q, shf1_q, msk0_q, msk1_q, rand_q;
  masked_alu_pkg::word_t and0, and1;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_ready <= 1'b0;
      {r_not, r_xor, r_and, r_ior, r_srli, r_slli, r_rori, r_mask, r_remask} <= '0;
    end else begin
      o_ready <= i_valid && !i_flush;
      if (i_valid) begin
        {r_not, r_xor, r_and, r_ior, r_srli, r_slli, r_rori, r_mask, r_remask} <=
          {i_is_not, i_is_xor, i_is_and, i_is_ior, i_is_srli,
           i_is_slli, i_is_rori, i_is_mask, i_is_remask};
      end
    end
  end

  // AND terms are held apart for a full cycle before recombining
  always_ff @(posedge g_clk) begin
    if (i_valid) begin
      t0_q   <= i_and_t0;
      t1_q   <= i_and_t1;
      t2_q   <= i_and_t2;
      t3_q   <= i_and_t3;
      lin0_q <= i_lin0;
      lin1_q <= i_lin1;
      shf0_q <= i_shf0;
      shf1_q <= i_shf1;
      msk0_q <= i_msk0;
      msk1_q <= i_msk1;
      rand_q <= i_rand;
    end
  end

  assign and0 = t0_q ^ t2_q;
  assign and1 = t1_q ^ t3_q;

  assign sel_lin = r_not | r_xor;
  assign sel_shf = r_srli | r_slli | r_rori;
  assign sel_msk = r_mask | r_remask;

  // Shift shares get a refresh on the way out
  assign o_rd_s0 = {XLEN{sel_lin}}       & lin0_q |
                   {XLEN{r_and | r_ior}} & and0 |
                   {XLEN{sel_shf}}       & (shf0_q ^ rand_q) |
                   {XLEN{sel_msk}}       & msk0_q;

  assign o_rd_s1 = {XLEN{sel_lin}} & lin1_q |
                   {XLEN{r_and}}   & and1 |
                   {XLEN{r_ior}}   & ~and1 | // De Morgan completes the OR
                   {XLEN{sel_shf}} & (shf1_q ^ rand_q) |
                   {XLEN{sel_msk}} & msk1_q;

  // Stage 1 must also come out of a flush empty
  a_no_ready_after_flush: assert property (@(posedge g_clk) disable iff (!g_resetn)
    $past(i_flush) |-> !o_ready && !i_valid)
    else $error("Result ready or stage 1 valid in the cycle after a flush");

endmodule

`default_nettype wire

/* design/masked_decode.sv */
`default_nettype none

module masked_decode #(
  parameter masked_alu_pkg::word_t prng_seed = masked_alu_pkg::PRNG_SEED
) (
  input  logic                   g_clk,
  input  logic                   g_resetn,
  input  logic                   i_valid,
  input  logic                   i_flush,
  input  logic                   i_prng_update,
  input  masked_alu_pkg::op_t    i_op,
  input  masked_alu_pkg::word_t  i_rs1_s0,
  input  masked_alu_pkg::word_t  i_rs1_s1,
  input  masked_alu_pkg::word_t  i_rs2_s0,
  input  masked_alu_pkg::word_t  i_rs2_s1,
  output logic                   o_valid,
  output logic                   o_is_not,
  output logic                   o_is_xor,
  output logic                   o_is_and,
  output logic                   o_is_ior,
  output logic                   o_is_srli,
  output logic                   o_is_slli,
  output logic                   o_is_rori,
  output logic                   o_is_mask,
  output logic                   o_is_remask,
  output masked_alu_pkg::word_t  o_a0,
  output masked_alu_pkg::word_t  o_a1,
  output masked_alu_pkg::word_t  o_b0,
  output masked_alu_pkg::word_t  o_b1,
  output masked_alu_pkg::shamt_t o_shamt,
  output masked_alu_pkg::word_t  o_rand
);

  masked_alu_pkg::word_t prng;
  masked_alu_pkg::word_t n_prng;
  logic                  n_prng_lsb;
  logic [8:0]            dec; // not xor and ior srli slli rori mask remask
  logic                  legal;

  assign n_prng_lsb = prng[masked_alu_pkg::PRNG_TAPS[0]] ~^ prng[masked_alu_pkg::PRNG_TAPS[1]]
                      ~^ prng[masked_alu_pkg::PRNG_TAPS[2]] ~^ prng[masked_alu_pkg::PRNG_TAPS[3]];
  assign n_prng     = {prng[masked_alu_pkg::XLEN-2:0], n_prng_lsb};

  // Steps once per issue or explicit update
  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      prng <= prng_seed;
    end else if (i_valid || i_prng_update) begin
      prng <= n_prng;
    end
  end

  always_comb begin
    dec = '0;
    case (i_op)
      masked_alu_pkg::OP_B_NOT:    dec[8] = 1'b1;
      masked_alu_pkg::OP_B_XOR:    dec[7] = 1'b1;
      masked_alu_pkg::OP_B_AND:    dec[6] = 1'b1;
      masked_alu_pkg::OP_B_IOR:    dec[5] = 1'b1;
      masked_alu_pkg::OP_B_SRLI:   dec[4] = 1'b1;
      masked_alu_pkg::OP_B_SLLI:   dec[3] = 1'b1;
      masked_alu_pkg::OP_B_RORI:   dec[2] = 1'b1;
      masked_alu_pkg::OP_B_MASK:   dec[1] = 1'b1;
      masked_alu_pkg::OP_B_REMASK: dec[0] = 1'b1;
      default:                     dec    = '0;
    endcase
  end

  assign legal = |dec; // Illegal codes never reach stage 1

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_valid <= 1'b0;
      {o_is_not, o_is_xor, o_is_and, o_is_ior, o_is_srli,
       o_is_slli, o_is_rori, o_is_mask, o_is_remask} <= '0;
    end else begin
      o_valid <= i_valid && legal && !i_flush; // Flush also drops a same-edge issue
      if (i_valid) begin
        {o_is_not, o_is_xor, o_is_and, o_is_ior, o_is_srli,
         o_is_slli, o_is_rori, o_is_mask, o_is_remask} <= dec;
      end
    end
  end

  // OR runs as NOT of AND over inverted inputs, so flip share 1 here
  always_ff @(posedge g_clk) begin
    if (i_valid) begin
      o_a0    <= i_rs1_s0;
      o_a1    <= dec[5] ? ~i_rs1_s1 : i_rs1_s1;
      o_b0    <= i_rs2_s0;
      o_b1    <= dec[5] ? ~i_rs2_s1 : i_rs2_s1;
      o_shamt <= i_rs2_s0[masked_alu_pkg::SHAMT_W-1:0];
      o_rand  <= n_prng; // Fresh word for this operation
    end
  end

  a_flags_onehot: assert property (@(posedge g_clk) disable iff (!g_resetn)
    o_valid |-> $onehot({o_is_not, o_is_xor, o_is_and, o_is_ior, o_is_srli,
                         o_is_slli, o_is_rori, o_is_mask, o_is_remask}))
    else $error("Stage 1 operation flags are not one-hot");

endmodule

`default_nettype wire

/* execute/masked_execute.sv */
`default_nettype none

module masked_execute (
  input  logic                   i_valid,
  input  logic                   i_is_not,
  input  logic                   i_is_xor,
  input  logic                   i_is_and,
  input  logic                   i_is_ior,
  input  logic                   i_is_srli,
  input  logic                   i_is_slli,
  input  logic                   i_is_rori,
  input  logic                   i_is_mask,
  input  logic                   i_is_remask,
  input  masked_alu_pkg::word_t  i_a0,
  input  masked_alu_pkg::word_t  i_a1,
  input  masked_alu_pkg::word_t  i_b0,
  input  masked_alu_pkg::word_t  i_b1,
  input  masked_alu_pkg::shamt_t i_shamt,
  input  masked_alu_pkg::word_t  i_rand,
  output logic                   o_valid,
  output logic                   o_is_not,
  output logic                   o_is_xor,
  output logic                   o_is_and,
  output logic                   o_is_ior,
  output logic                   o_is_srli,
  output logic                   o_is_slli,
  output logic                   o_is_rori,
  output logic                   o_is_mask,
  output logic                   o_is_remask,
  output masked_alu_pkg::word_t  o_and_t0,
  output masked_alu_pkg::word_t  o_and_t1,
  output masked_alu_pkg::word_t  o_and_t2,
  output masked_alu_pkg::word_t  o_and_t3,
  output masked_alu_pkg::word_t  o_lin0,
  output masked_alu_pkg::word_t  o_lin1,
  output masked_alu_pkg::word_t  o_shf0,
  output masked_alu_pkg::word_t  o_shf1,
  output masked_alu_pkg::word_t  o_msk0,
  output masked_alu_pkg::word_t  o_msk1,
  output masked_alu_pkg::word_t  o_rand
);

  masked_alu_pkg::word_t msk_base;

  assign o_valid     = i_valid;
  assign o_rand      = i_rand;
  assign {o_is_not, o_is_xor, o_is_and, o_is_ior, o_is_srli} =
         {i_is_not, i_is_xor, i_is_and, i_is_ior, i_is_srli};
  assign {o_is_slli, o_is_rori, o_is_mask, o_is_remask} =
         {i_is_slli, i_is_rori, i_is_mask, i_is_remask};

  // Threshold AND terms, each touches at most one share of either operand
  assign o_and_t0 = i_rand ^ (i_a0 & i_b0);
  assign o_and_t1 = i_rand ^ (i_a0 & i_b1);
  assign o_and_t2 = i_a1 & i_b0;
  assign o_and_t3 = i_a1 & i_b1;

  // NOT flips share 1, XOR is share-wise, both refreshed
  assign o_lin0 = (i_is_not ? i_a0 : i_a0 ^ i_b0) ^ i_rand;
  assign o_lin1 = (i_is_not ? ~i_a1 : i_a1 ^ i_b1) ^ i_rand;

  assign msk_base = i_a0 ^ i_rand;
  assign o_msk0   = i_is_remask ? msk_base ^ i_a1 : msk_base; // Remask folds in old share 1
  assign o_msk1   = i_rand;

  masked_shift u_shift_s0 (
    .i_share (i_a0),
    .i_shamt (i_shamt),
    .i_pad   (i_rand),
    .i_srli  (i_is_srli),
    .i_slli  (i_is_slli),
    .i_rori  (i_is_rori),
    .o_share (o_shf0)
  );

  // Same padding on both shares so it cancels on unmasking
  masked_shift u_shift_s1 (
    .i_share (i_a1),
    .i_shamt (i_shamt),
    .i_pad   (i_rand),
    .i_srli  (i_is_srli),
    .i_slli  (i_is_slli),
    .i_rori  (i_is_rori),
    .o_share (o_shf1)
  );

  always_comb begin
    if (i_valid === 1'b1) begin
      a_shift_excl: assert ($onehot0({i_is_srli, i_is_slli, i_is_rori}))
        else $error("More than one shift flag set");
    end
  end

endmodule

`default_nettype wire

/* execute/masked_shift.sv */
`default_nettype none

module masked_shift (
  input  masked_alu_pkg::word_t  i_share,
  input  masked_alu_pkg::shamt_t i_shamt,
  input  masked_alu_pkg::word_t  i_pad,
  input  logic                   i_srli,
  input  logic                   i_slli,
  input  logic                   i_rori,
  output masked_alu_pkg::word_t  o_share
);

  localparam int XLEN = masked_alu_pkg::XLEN;

  logic go_right;

  assign go_right = i_srli | i_rori;

  // Level k moves by 2**k and draws its own slice of padding
  for (genvar k = 0; k < masked_alu_pkg::SHAMT_W; k++) begin : g_level
    localparam int W = 1 << k;

    masked_alu_pkg::word_t lvl_in;
    masked_alu_pkg::word_t lvl_out;
    logic [W-1:0]          fill_r;
    logic [W-1:0]          fill_l;
    masked_alu_pkg::word_t sh_l;
    masked_alu_pkg::word_t sh_r;

    if (k == 0) begin : g_first
      assign lvl_in = i_share;
    end else begin : g_next
      assign lvl_in = g_level[k-1].lvl_out;
    end

    assign fill_r = i_rori ? lvl_in[W-1:0] : i_pad[2*W-2 -: W]; // Rotate reuses bits pushed out
    assign fill_l = i_pad[XLEN-W -: W];

    assign sh_l = {lvl_in[XLEN-1-W:0], fill_l};
    assign sh_r = {fill_r, lvl_in[XLEN-1:W]};

    always_comb begin
      if (!i_shamt[k]) begin
        lvl_out = lvl_in;
      end else if (i_slli) begin
        lvl_out = sh_l;
      end else if (go_right) begin
        lvl_out = sh_r;
      end else begin
        lvl_out = lvl_in; // No shift operation
      end
    end
  end

  assign o_share = g_level[masked_alu_pkg::SHAMT_W-1].lvl_out;

endmodule

`default_nettype wire

/* common/masked_alu_pkg.sv */
`default_nettype none

package masked_alu_pkg;

  localparam int XLEN    = 32;
  localparam int SHAMT_W = 5;

  // One share of a masked value
  typedef logic [XLEN-1:0]    word_t;
  typedef logic [SHAMT_W-1:0] shamt_t;

  // Masked Boolean operations. Any other code is illegal
  typedef enum logic [3:0] {
    OP_B_MASK   = 4'h0,
    OP_B_REMASK = 4'h1,
    OP_B_NOT    = 4'h2,
    OP_B_XOR    = 4'h3,
    OP_B_AND    = 4'h4,
    OP_B_IOR    = 4'h5,
    OP_B_SRLI   = 4'h6,
    OP_B_SLLI   = 4'h7,
    OP_B_RORI   = 4'h8
  } op_t;

  // LFSR reset value
  localparam word_t PRNG_SEED = 32'h6789ABCD;

  // Bits XNORed into the next LSB, register shifts left
  localparam int PRNG_TAPS [4] = '{31, 21, 1, 0};

endpackage

`default_nettype wire
